// ==== logic/rvfi_monitor_pkg.sv ====
// Widths assume RV64 with Sv39 and 56-bit physical addresses and the core must retire on two RVFI ports
package rvfi_monitor_pkg;

  // Number of RVFI retirement ports of the core
  localparam int unsigned NrCommitPorts = 2;

  // Integer register width, also selects the compressed FP load encoding
  localparam int unsigned Xlen = 64;

  // Virtual PC width, sign-extended to Xlen when a trap record is built
  localparam int unsigned Vlen = 39;

  // Physical address width of the memory port
  localparam int unsigned Plen = 56;

  // Full instruction word width
  localparam int unsigned InsnWidth = 32;

  // Width of every statistics counter and of the timeout limit
  localparam int unsigned CountWidth = 32;

  // Width of the end-of-test word
  localparam int unsigned ResultWidth = 32;

  // End-of-test word reported when the cycle limit is exceeded
  localparam logic [ResultWidth-1:0] TimeoutResult = {ResultWidth{1'b1}};

  // What one commit port did in a cycle
  // KIND_IDLE marks a port with neither valid nor trap
  // KIND_NONE is a retired instruction that wrote nothing the monitor tracks
  typedef enum logic [2:0] {
    KIND_IDLE      = 3'd0,
    KIND_NONE      = 3'd1,
    KIND_FP_WRITE  = 3'd2,
    KIND_INT_WRITE = 3'd3,
    KIND_STORE     = 3'd4,
    KIND_TRAP      = 3'd5
  } commit_kind_e;

  // Test progress, DONE is left only by reset
  typedef enum logic {
    ST_RUN  = 1'b0,
    ST_DONE = 1'b1
  } test_state_e;

endpackage

// ==== logic/commit_classifier.sv ====
// Decodes one RVFI port per cycle and expects valid and trap never to be high together on a port
module commit_classifier import rvfi_monitor_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  valid_i,
  input  logic                  trap_i,
  input  logic [InsnWidth-1:0]  insn_i,
  input  logic [4:0]            rd_addr_i,
  input  logic [Xlen/8-1:0]     mem_wmask_i,
  output commit_kind_e          kind_o
);

  logic [6:0] opcode;
  logic [5:0] funct6;
  logic [2:0] c_funct3;
  logic [2:0] c_fp_load_funct3;
  logic       is_fp_load;
  logic       is_fma;
  logic       is_op_fp;
  logic       is_c_fp_load;
  logic       fp_write;

  assign opcode   = insn_i[6:0];
  assign funct6   = insn_i[31:26];
  assign c_funct3 = insn_i[15:13];

  // C.FLD/C.FLDSP on RV64, C.FLW/C.FLWSP on RV32
  assign c_fp_load_funct3 = (Xlen == 64) ? 3'b001 : 3'b011;

  // LOAD-FP
  assign is_fp_load = (opcode == 7'b0000111);

  // FMADD, FMSUB, FNMSUB, FNMADD
  assign is_fma = (opcode == 7'b1000011) || (opcode == 7'b1000111) ||
                  (opcode == 7'b1001011) || (opcode == 7'b1001111);

  // OP-FP minus the groups that write x registers
  // 111000 is FMV.X and FCLASS, 101000 compares, 110000 FCVT to integer
  assign is_op_fp = (opcode == 7'b1010011) &&
                    (funct6 != 6'b111000) &&
                    (funct6 != 6'b101000) &&
                    (funct6 != 6'b110000);

  // Compressed quadrants 0 and 2 have bit 0 low
  assign is_c_fp_load = !insn_i[0] && (c_funct3 == c_fp_load_funct3);

  assign fp_write = is_fp_load || is_fma || is_op_fp || is_c_fp_load;

  // Ordered decode, FP destination first
  always_comb begin
    kind_o = KIND_IDLE;
    if (valid_i) begin
      if (fp_write) begin
        kind_o = KIND_FP_WRITE;
      end else if (rd_addr_i != 5'd0) begin
        kind_o = KIND_INT_WRITE;
      end else if (mem_wmask_i != '0) begin
        kind_o = KIND_STORE;
      end else begin
        kind_o = KIND_NONE;
      end
    end else if (trap_i) begin
      kind_o = KIND_TRAP;
    end
  end

  // A port either retires or traps in a cycle
  valid_trap_exclusive_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(valid_i && trap_i)
  ) else $error("valid and trap high together on one commit port");

endmodule

// ==== logic/tohost_detector.sv ====
// Combinational tohost match over all ports where a zero tohost address disables detection
module tohost_detector import rvfi_monitor_pkg::*; (
  input  commit_kind_e [NrCommitPorts-1:0]             kind_i,
  input  logic         [NrCommitPorts-1:0][Plen-1:0]   mem_paddr_i,
  input  logic         [NrCommitPorts-1:0][Xlen-1:0]   mem_wdata_i,
  input  logic         [Plen-1:0]                      tohost_addr_i,
  output logic                                         hit_o,
  output logic         [ResultWidth-1:0]               code_o
);

  logic                     tohost_en;
  logic [NrCommitPorts-1:0] qualify;

  assign tohost_en = (tohost_addr_i != '0);

  // A store to tohost only ends the test with data bit 0 set
  always_comb begin
    for (int unsigned i = 0; i < NrCommitPorts; i++) begin
      qualify[i] = tohost_en &&
                   (kind_i[i] == KIND_STORE) &&
                   (mem_paddr_i[i] == tohost_addr_i) &&
                   mem_wdata_i[i][0];
    end
  end

  assign hit_o = |qualify;

  // Ascending scan, so the highest qualifying port wins
  always_comb begin
    code_o = '0;
    for (int unsigned i = 0; i < NrCommitPorts; i++) begin
      if (qualify[i]) begin
        code_o = mem_wdata_i[i][ResultWidth-1:0];
      end
    end
  end

endmodule

// ==== logic/cycle_timer.sv ====
// Saturating cycle counter whose limit_i must stay stable between resets
module cycle_timer import rvfi_monitor_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [CountWidth-1:0] limit_i,
  output logic                  timeout_o
);

  logic [CountWidth-1:0] count_q;

  // Edges since reset, stuck at the top value
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (count_q != {CountWidth{1'b1}}) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign timeout_o = (count_q > limit_i);

  // Once expired the timer stays expired until the next reset
  timeout_sticky_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    timeout_o |=> timeout_o
  ) else $error("timeout dropped without a reset");

endmodule

// ==== logic/test_control_fsm.sv ====
// Captures the first end-of-test event after reset and a timeout beats a tohost hit in the same cycle
module test_control_fsm import rvfi_monitor_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   tohost_hit_i,
  input  logic [ResultWidth-1:0] tohost_code_i,
  input  logic                   timeout_i,
  output logic                   running_o,
  output logic [ResultWidth-1:0] end_of_test_o
);

  test_state_e            state_q;
  test_state_e            state_d;
  logic [ResultWidth-1:0] result_q;
  logic [ResultWidth-1:0] result_d;

  always_comb begin
    state_d  = state_q;
    result_d = result_q;
    unique case (state_q)
      ST_RUN: begin
        if (timeout_i) begin
          result_d = TimeoutResult;
          state_d  = ST_DONE;
        end else if (tohost_hit_i) begin
          result_d = tohost_code_i;
          state_d  = ST_DONE;
        end
      end
      // Result is frozen until reset
      ST_DONE: begin
        state_d  = ST_DONE;
        result_d = result_q;
      end
      default: begin
        state_d = ST_RUN;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q  <= ST_RUN;
      result_q <= '0;
    end else begin
      state_q  <= state_d;
      result_q <= result_d;
    end
  end

  assign running_o     = (state_q == ST_RUN);
  assign end_of_test_o = result_q;

  // Once done, the word seen by the testbench never moves
  result_frozen_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (state_q == ST_DONE) |=> (state_q == ST_DONE) && $stable(end_of_test_o)
  ) else $error("end_of_test changed after the test ended");

endmodule

// ==== logic/commit_stats.sv ====
// Counts commits of all ports while running and the counters wrap at CountWidth bits
module commit_stats import rvfi_monitor_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  commit_kind_e [NrCommitPorts-1:0]    kind_i,
  input  logic                                running_i,
  output logic         [CountWidth-1:0]       retired_count_o,
  output logic         [CountWidth-1:0]       trap_count_o,
  output logic         [CountWidth-1:0]       fp_write_count_o,
  output logic         [CountWidth-1:0]       store_count_o
);

  logic [CountWidth-1:0] retired_inc;
  logic [CountWidth-1:0] trap_inc;
  logic [CountWidth-1:0] fp_write_inc;
  logic [CountWidth-1:0] store_inc;

  // Per-cycle increments, 0 up to NrCommitPorts each
  always_comb begin
    retired_inc  = '0;
    trap_inc     = '0;
    fp_write_inc = '0;
    store_inc    = '0;
    for (int unsigned i = 0; i < NrCommitPorts; i++) begin
      case (kind_i[i])
        KIND_FP_WRITE: begin
          fp_write_inc = fp_write_inc + 1'b1;
          retired_inc  = retired_inc + 1'b1;
        end
        KIND_STORE: begin
          store_inc   = store_inc + 1'b1;
          retired_inc = retired_inc + 1'b1;
        end
        KIND_INT_WRITE, KIND_NONE: begin
          retired_inc = retired_inc + 1'b1;
        end
        KIND_TRAP: begin
          trap_inc = trap_inc + 1'b1;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      retired_count_o  <= '0;
      trap_count_o     <= '0;
      fp_write_count_o <= '0;
      store_count_o    <= '0;
    end else if (running_i) begin
      retired_count_o  <= retired_count_o + retired_inc;
      trap_count_o     <= trap_count_o + trap_inc;
      fp_write_count_o <= fp_write_count_o + fp_write_inc;
      store_count_o    <= store_count_o + store_inc;
    end
  end

  // Counters are frozen as soon as the controller leaves RUN
  counts_frozen_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !running_i |=> $stable(retired_count_o) && $stable(trap_count_o) &&
                   $stable(fp_write_count_o) && $stable(store_count_o)
  ) else $error("statistics changed after the test ended");

endmodule

// ==== logic/rvfi_monitor.sv ====
// Two-port RVFI commit monitor where end_of_test_o bit 0 marks the end and all ones means timeout
module rvfi_monitor import rvfi_monitor_pkg::*; (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic [NrCommitPorts-1:0]                rvfi_valid_i,
  input  logic [NrCommitPorts-1:0]                rvfi_trap_i,
  input  logic [NrCommitPorts-1:0][InsnWidth-1:0] rvfi_insn_i,
  input  logic [NrCommitPorts-1:0][4:0]           rvfi_rd_addr_i,
  input  logic [NrCommitPorts-1:0][Xlen/8-1:0]    rvfi_mem_wmask_i,
  input  logic [NrCommitPorts-1:0][Plen-1:0]      rvfi_mem_paddr_i,
  input  logic [NrCommitPorts-1:0][Xlen-1:0]      rvfi_mem_wdata_i,
  input  logic [Plen-1:0]                         tohost_addr_i,
  input  logic [CountWidth-1:0]                   timeout_cycles_i,
  output logic [ResultWidth-1:0]                  end_of_test_o,
  output logic [CountWidth-1:0]                   retired_count_o,
  output logic [CountWidth-1:0]                   trap_count_o,
  output logic [CountWidth-1:0]                   fp_write_count_o,
  output logic [CountWidth-1:0]                   store_count_o
);

  commit_kind_e [NrCommitPorts-1:0] kind;
  logic                             tohost_hit;
  logic [ResultWidth-1:0]           tohost_code;
  logic                             timeout;
  logic                             running;

  // One decoder per retirement port
  for (genvar p = 0; p < NrCommitPorts; p++) begin : gen_classifier
    commit_classifier commit_classifier_i (
      .clk_i       ( clk_i               ),
      .rst_ni      ( rst_ni              ),
      .valid_i     ( rvfi_valid_i[p]     ),
      .trap_i      ( rvfi_trap_i[p]      ),
      .insn_i      ( rvfi_insn_i[p]      ),
      .rd_addr_i   ( rvfi_rd_addr_i[p]   ),
      .mem_wmask_i ( rvfi_mem_wmask_i[p] ),
      .kind_o      ( kind[p]             )
    );
  end

  tohost_detector tohost_detector_i (
    .kind_i        ( kind             ),
    .mem_paddr_i   ( rvfi_mem_paddr_i ),
    .mem_wdata_i   ( rvfi_mem_wdata_i ),
    .tohost_addr_i ( tohost_addr_i    ),
    .hit_o         ( tohost_hit       ),
    .code_o        ( tohost_code      )
  );

  cycle_timer cycle_timer_i (
    .clk_i     ( clk_i            ),
    .rst_ni    ( rst_ni           ),
    .limit_i   ( timeout_cycles_i ),
    .timeout_o ( timeout          )
  );

  test_control_fsm test_control_fsm_i (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .tohost_hit_i  ( tohost_hit    ),
    .tohost_code_i ( tohost_code   ),
    .timeout_i     ( timeout       ),
    .running_o     ( running       ),
    .end_of_test_o ( end_of_test_o )
  );

  // Statistics stop on the edge after the FSM reaches DONE
  commit_stats commit_stats_i (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .kind_i           ( kind             ),
    .running_i        ( running          ),
    .retired_count_o  ( retired_count_o  ),
    .trap_count_o     ( trap_count_o     ),
    .fp_write_count_o ( fp_write_count_o ),
    .store_count_o    ( store_count_o    )
  );

endmodule

// ==== testbench/tb_rvfi_monitor.sv ====
// Assumes the two-port RV64 widths of the package; inputs change on the falling clock edge only
module tb_rvfi_monitor import rvfi_monitor_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  logic                                    clk_i;
  logic                                    rst_ni;
  logic [NrCommitPorts-1:0]                rvfi_valid;
  logic [NrCommitPorts-1:0]                rvfi_trap;
  logic [NrCommitPorts-1:0][InsnWidth-1:0] rvfi_insn;
  logic [NrCommitPorts-1:0][4:0]           rvfi_rd_addr;
  logic [NrCommitPorts-1:0][Xlen/8-1:0]    rvfi_mem_wmask;
  logic [NrCommitPorts-1:0][Plen-1:0]      rvfi_mem_paddr;
  logic [NrCommitPorts-1:0][Xlen-1:0]      rvfi_mem_wdata;
  logic [Plen-1:0]                         tohost_addr;
  logic [CountWidth-1:0]                   timeout_cycles;
  logic [ResultWidth-1:0]                  end_of_test;
  logic [CountWidth-1:0]                   retired_count;
  logic [CountWidth-1:0]                   trap_count;
  logic [CountWidth-1:0]                   fp_write_count;
  logic [CountWidth-1:0]                   store_count;

  // Reference model state
  logic [CountWidth-1:0]  exp_retired;
  logic [CountWidth-1:0]  exp_trap;
  logic [CountWidth-1:0]  exp_fp_write;
  logic [CountWidth-1:0]  exp_store;
  logic [ResultWidth-1:0] exp_result;
  logic [CountWidth-1:0]  exp_cycles;
  logic                   exp_running;
  logic                   model_ready = 1'b0;

  int    errors = 0;
  int    errors_at_start = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  string test_name;

  rvfi_monitor rvfi_monitor_i (
    .clk_i            ( clk_i          ),
    .rst_ni           ( rst_ni         ),
    .rvfi_valid_i     ( rvfi_valid     ),
    .rvfi_trap_i      ( rvfi_trap      ),
    .rvfi_insn_i      ( rvfi_insn      ),
    .rvfi_rd_addr_i   ( rvfi_rd_addr   ),
    .rvfi_mem_wmask_i ( rvfi_mem_wmask ),
    .rvfi_mem_paddr_i ( rvfi_mem_paddr ),
    .rvfi_mem_wdata_i ( rvfi_mem_wdata ),
    .tohost_addr_i    ( tohost_addr    ),
    .timeout_cycles_i ( timeout_cycles ),
    .end_of_test_o    ( end_of_test    ),
    .retired_count_o  ( retired_count  ),
    .trap_count_o     ( trap_count     ),
    .fp_write_count_o ( fp_write_count ),
    .store_count_o    ( store_count    )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Expected kind of one commit port
  function automatic commit_kind_e classify_ref(input logic valid, input logic trap,
      input logic [InsnWidth-1:0] insn, input logic [4:0] rd, input logic [Xlen/8-1:0] wmask);
    logic [6:0] op;
    logic [4:0] f5;
    logic       fp;
    op = insn[6:0];
    f5 = insn[31:27];
    fp = 1'b0;
    // LOAD-FP and the four fused multiply-add opcodes
    if (op == 7'h07 || op == 7'h43 || op == 7'h47 || op == 7'h4b || op == 7'h4f) begin
      fp = 1'b1;
    end
    // OP-FP minus FMV.X/FCLASS, compares and FCVT to integer for S and D
    if (op == 7'h53) begin
      fp = !(!insn[26] && (f5 == 5'b11100 || f5 == 5'b10100 || f5 == 5'b11000));
    end
    if (!insn[0] && insn[15:13] == ((Xlen == 64) ? 3'b001 : 3'b011)) begin
      fp = 1'b1;
    end
    if (valid) begin
      if (fp) begin
        return KIND_FP_WRITE;
      end else if (rd != 5'd0) begin
        return KIND_INT_WRITE;
      end else if (wmask != '0) begin
        return KIND_STORE;
      end
      return KIND_NONE;
    end else if (trap) begin
      return KIND_TRAP;
    end
    return KIND_IDLE;
  endfunction

  // Model follows the DUT rules on every rising edge
  always @(posedge clk_i) begin
    commit_kind_e           k;
    logic                   hit;
    logic [ResultWidth-1:0] code;
    logic                   expired;
    if (!rst_ni) begin
      exp_retired  = '0;
      exp_trap     = '0;
      exp_fp_write = '0;
      exp_store    = '0;
      exp_result   = '0;
      exp_cycles   = '0;
      exp_running  = 1'b1;
      model_ready  = 1'b1;
    end else begin
      expired = (exp_cycles > timeout_cycles);
      hit     = 1'b0;
      code    = '0;
      for (int p = 0; p < NrCommitPorts; p++) begin
        k = classify_ref(rvfi_valid[p], rvfi_trap[p], rvfi_insn[p], rvfi_rd_addr[p],
                         rvfi_mem_wmask[p]);
        if (exp_running) begin
          exp_fp_write += CountWidth'(k == KIND_FP_WRITE);
          exp_store    += CountWidth'(k == KIND_STORE);
          exp_trap     += CountWidth'(k == KIND_TRAP);
          exp_retired  += CountWidth'(k != KIND_TRAP && k != KIND_IDLE);
        end
        if (k == KIND_STORE && tohost_addr != '0 && rvfi_mem_paddr[p] == tohost_addr &&
            rvfi_mem_wdata[p][0]) begin
          hit  = 1'b1;
          code = rvfi_mem_wdata[p][ResultWidth-1:0];
        end
      end
      if (exp_running && expired) begin
        exp_result  = TimeoutResult;
        exp_running = 1'b0;
      end else if (exp_running && hit) begin
        exp_result  = code;
        exp_running = 1'b0;
      end
      if (exp_cycles != {CountWidth{1'b1}}) begin
        exp_cycles = exp_cycles + 1'b1;
      end
    end
  end

  task automatic check_count(input logic [CountWidth-1:0] actual,
                             input logic [CountWidth-1:0] expected, input string name);
    if (actual !== expected) begin
      $display("** Error: %s = %h, expected %h", name, actual, expected);
      errors++;
    end
  endtask

  task automatic check_result(input logic [ResultWidth-1:0] actual,
                              input logic [ResultWidth-1:0] expected);
    if (actual !== expected) begin
      $display("** Error: end_of_test_o = %h, expected %h", actual, expected);
      errors++;
    end
  endtask

  // Outputs are registered, so the falling edge sees them settled
  always @(negedge clk_i) begin
    if (model_ready) begin
      check_count(retired_count, exp_retired, "retired_count_o");
      check_count(trap_count, exp_trap, "trap_count_o");
      check_count(fp_write_count, exp_fp_write, "fp_write_count_o");
      check_count(store_count, exp_store, "store_count_o");
      check_result(end_of_test, exp_result);
    end
  end

  task automatic set_idle();
    rvfi_valid     = '0;
    rvfi_trap      = '0;
    rvfi_insn      = '0;
    rvfi_rd_addr   = '0;
    rvfi_mem_wmask = '0;
    rvfi_mem_paddr = '0;
    rvfi_mem_wdata = '0;
  endtask

  // The cycle limit only changes while reset is held
  task automatic apply_reset(input logic [CountWidth-1:0] limit);
    @(negedge clk_i);
    rst_ni         = 1'b0;
    timeout_cycles = limit;
    set_idle();
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  // Random commit on one port; paddr upper bits keep it clear of tohost
  task automatic drive_random_port(input int p);
    int unsigned cat;
    logic [31:0] r;
    cat = $urandom_range(0, 9);
    r   = $urandom;
    rvfi_valid[p]     = 1'b1;
    rvfi_trap[p]      = 1'b0;
    rvfi_insn[p]      = r;
    rvfi_rd_addr[p]   = 5'($urandom_range(1, 31));
    rvfi_mem_wmask[p] = '0;
    rvfi_mem_paddr[p] = {16'h00f0, $urandom, 8'h00};
    rvfi_mem_wdata[p] = {$urandom, $urandom};
    case (cat)
      0: rvfi_valid[p] = 1'b0;
      1: begin
        rvfi_valid[p] = 1'b0;
        rvfi_trap[p]  = 1'b1;
      end
      2: rvfi_insn[p][6:0] = 7'b0000111;
      3: rvfi_insn[p][6:0] = {3'b100, r[10:9], 2'b11};
      4: begin
        rvfi_insn[p][6:0] = 7'b1010011;
        case ($urandom_range(0, 3))
          0: rvfi_insn[p][31:27] = 5'b11100;
          1: rvfi_insn[p][31:27] = 5'b10100;
          2: rvfi_insn[p][31:27] = 5'b11000;
          default: rvfi_insn[p][31:27] = 5'b00011;
        endcase
      end
      5: begin
        rvfi_insn[p][0]     = 1'b0;
        rvfi_insn[p][15:13] = 3'b001;
      end
      6: begin
        rvfi_insn[p][0]     = 1'b0;
        rvfi_insn[p][15:13] = 3'b010;
      end
      // Integer write wins over a nonzero mask
      7: begin
        rvfi_insn[p][6:0] = 7'b0110011;
        rvfi_mem_wmask[p] = 8'($urandom);
      end
      8: begin
        rvfi_insn[p][6:0] = 7'b0100011;
        rvfi_rd_addr[p]   = 5'd0;
        rvfi_mem_wmask[p] = 8'($urandom_range(1, 255));
      end
      default: begin
        rvfi_insn[p][6:0] = 7'b1110011;
        rvfi_rd_addr[p]   = 5'd0;
      end
    endcase
  endtask

  task automatic run_random(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      for (int p = 0; p < NrCommitPorts; p++) begin
        drive_random_port(p);
      end
    end
  endtask

  // SD with a full byte mask
  task automatic drive_store(input int p, input logic [Plen-1:0] addr,
                             input logic [Xlen-1:0] data);
    rvfi_valid[p]     = 1'b1;
    rvfi_trap[p]      = 1'b0;
    rvfi_insn[p]      = 32'h00a53023;
    rvfi_rd_addr[p]   = 5'd0;
    rvfi_mem_wmask[p] = 8'hff;
    rvfi_mem_paddr[p] = addr;
    rvfi_mem_wdata[p] = data;
  endtask

  task automatic wait_for_end(input int max_cycles);
    int n;
    n = 0;
    while (end_of_test[0] !== 1'b1 && n < max_cycles) begin
      @(negedge clk_i);
      set_idle();
      n++;
    end
    if (end_of_test[0] !== 1'b1) begin
      $display("Timeout: end of test not reported within %0d cycles", max_cycles);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
    tests_run++;
  endtask

  task automatic finish_test();
    if (errors == errors_at_start) begin
      $display("test %0d %s: ok", tests_run, test_name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, test_name, errors - errors_at_start);
    end
  endtask

  initial begin
    int n;
    void'($urandom(32'hacd2));
    rst_ni         = 1'b0;
    tohost_addr    = '0;
    timeout_cycles = 32'd100000;
    set_idle();

    start_test("random commits");
    apply_reset(32'd100000);
    run_random(400);
    finish_test();

    start_test("tohost end");
    apply_reset(32'd100000);
    tohost_addr = 56'h0000_0080_0010_00;
    run_random(20);
    @(negedge clk_i);
    drive_store(0, tohost_addr, 64'hdead_beef_0000_0c01);
    wait_for_end(10);
    check_result(end_of_test, 32'h0000_0c01);
    run_random(20);
    @(negedge clk_i);
    drive_store(1, tohost_addr, 64'h0000_0000_0000_0d01);
    run_random(5);
    check_result(end_of_test, 32'h0000_0c01);
    finish_test();

    start_test("non-qualifying stores");
    apply_reset(32'd100000);
    for (int i = 0; i < 8; i++) begin
      @(negedge clk_i);
      drive_store(i % 2, tohost_addr, {$urandom, $urandom} & ~64'h1);
    end
    tohost_addr = '0;
    @(negedge clk_i);
    drive_store(0, '0, 64'h0000_0000_0000_0e01);
    drive_store(1, 56'h0000_0080_0010_00, 64'h0000_0000_0000_0e03);
    run_random(4);
    check_result(end_of_test, '0);
    finish_test();

    start_test("two-port tohost");
    apply_reset(32'd100000);
    tohost_addr = 56'h0000_0080_0010_00;
    run_random(10);
    @(negedge clk_i);
    drive_store(0, tohost_addr, 64'h1111_2222_0000_0a01);
    drive_store(1, tohost_addr, 64'h3333_4444_0000_0b05);
    wait_for_end(10);
    check_result(end_of_test, 32'h0000_0b05);
    finish_test();

    start_test("timeout");
    apply_reset(32'd12);
    wait_for_end(40);
    check_result(end_of_test, TimeoutResult);
    // Tohost hit placed in the cycle where the timer first expires
    apply_reset(32'd20);
    n = 0;
    while (exp_cycles != timeout_cycles + 1 && n < 60) begin
      @(negedge clk_i);
      set_idle();
      n++;
    end
    if (exp_cycles != timeout_cycles + 1) begin
      $display("Timeout: timer never reached its limit");
      errors++;
    end
    drive_store(1, tohost_addr, 64'h0000_0000_0000_0f01);
    wait_for_end(10);
    check_result(end_of_test, TimeoutResult);
    finish_test();

    start_test("reset mid-run");
    tohost_addr = '0;
    apply_reset(32'd100000);
    run_random(30);
    apply_reset(32'd100000);
    @(negedge clk_i);
    check_count(retired_count, '0, "retired_count_o");
    check_count(trap_count, '0, "trap_count_o");
    check_count(fp_write_count, '0, "fp_write_count_o");
    check_count(store_count, '0, "store_count_o");
    check_result(end_of_test, '0);
    run_random(30);
    @(negedge clk_i);
    set_idle();
    if (retired_count == '0) begin
      $display("Counters did not resume after reset");
      errors++;
    end
    finish_test();

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== rvfi_monitor.f ====
logic/rvfi_monitor_pkg.sv
logic/commit_classifier.sv
logic/tohost_detector.sv
logic/cycle_timer.sv
logic/test_control_fsm.sv
logic/commit_stats.sv
logic/rvfi_monitor.sv
testbench/tb_rvfi_monitor.sv

// ==== Bender.yml ====
package:
  name: rvfi_monitor

sources:
  - logic/rvfi_monitor_pkg.sv
  - logic/commit_classifier.sv
  - logic/tohost_detector.sv
  - logic/cycle_timer.sv
  - logic/test_control_fsm.sv
  - logic/commit_stats.sv
  - logic/rvfi_monitor.sv
  - target: simulation
    files:
      - testbench/tb_rvfi_monitor.sv
